// File: source/udp_loop_pkg.sv
package udp_loop_pkg;

    // Field widths of the UDP frame as seen by the loopback core
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  ttl_t;

    // Payload stream, 64-bit beats with byte enables
    typedef logic [63:0] data_t;
    typedef logic [7:0]  keep_t;

    typedef logic [7:0]  led_t;

    // Configuration write port
    typedef logic [31:0] cfg_data_t;

    typedef enum logic [1:0] {
        CFG_LOCAL_IP    = 2'd0,
        CFG_LISTEN_PORT = 2'd1,
        CFG_TTL         = 2'd2
    } cfg_addr_e;

    // Per-frame decision of the port filter
    typedef enum logic [1:0] {
        IDLE,
        PASS,
        DROP
    } filter_state_e;

    // 192.168.1.128
    localparam ip_addr_t DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    localparam udp_port_t DEFAULT_LISTEN_PORT = 16'd1234;

    localparam ttl_t DEFAULT_TTL = 8'd64;

endpackage

// File: source/loop_config.sv
`timescale 1ns/1ps

module loop_config #(
    parameter udp_loop_pkg::ttl_t RESET_TTL = udp_loop_pkg::DEFAULT_TTL
) (
    input  logic                   clk,
    input  logic                   rst,

    // Write strobe
    input  logic                   cfg_we,
    input  udp_loop_pkg::cfg_addr_e cfg_addr,
    input  udp_loop_pkg::cfg_data_t cfg_wdata,

    // Current settings
    output udp_loop_pkg::ip_addr_t  local_ip,
    output udp_loop_pkg::udp_port_t listen_port,
    output udp_loop_pkg::ttl_t      ttl
);

    import udp_loop_pkg::*;

    // Each register takes the low bits of the write data
    always_ff @(posedge clk) begin
        if (rst) begin
            local_ip    <= DEFAULT_LOCAL_IP;
            listen_port <= DEFAULT_LISTEN_PORT;
            ttl         <= RESET_TTL;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_LOCAL_IP: begin
                    local_ip <= cfg_wdata;
                end
                CFG_LISTEN_PORT: begin
                    listen_port <= cfg_wdata[15:0];
                end
                CFG_TTL: begin
                    ttl <= cfg_wdata[7:0];
                end
                default: begin
                    // Unmapped address, nothing to update
                end
            endcase
        end
    end

endmodule

// File: source/port_filter.sv
`timescale 1ns/1ps

module port_filter (
    input  logic                    clk,
    input  logic                    rst,

    input  udp_loop_pkg::udp_port_t listen_port,

    // Received header
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    input  udp_loop_pkg::udp_port_t rx_dst_port,

    // Received payload
    input  logic                    rx_valid,
    output logic                    rx_ready,
    input  udp_loop_pkg::data_t     rx_data,
    input  udp_loop_pkg::keep_t     rx_keep,
    input  logic                    rx_last,

    // Header responder
    output logic                    hdr_load,
    input  logic                    hdr_busy,

    // Payload relay
    output logic                    relay_valid,
    input  logic                    relay_ready,
    output udp_loop_pkg::data_t     relay_data,
    output udp_loop_pkg::keep_t     relay_keep,
    output logic                    relay_last
);

    import udp_loop_pkg::*;

    filter_state_e state;
    filter_state_e state_next;

    logic hdr_xfer;
    logic port_match;
    logic last_xfer;

    // A new header is only taken once the previous response has left
    assign rx_hdr_ready = (state == IDLE) && !hdr_busy;
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;
    assign port_match   = (rx_dst_port == listen_port);
    assign hdr_load     = hdr_xfer && port_match;

    // Dropped frames are sunk at full rate
    always_comb begin
        case (state)
            PASS:    rx_ready = relay_ready;
            DROP:    rx_ready = 1'b1;
            default: rx_ready = 1'b0;
        endcase
    end

    assign last_xfer = rx_valid && rx_ready && rx_last;

    // Beats of a matching frame go straight to the output register
    assign relay_valid = (state == PASS) && rx_valid;
    assign relay_data  = rx_data;
    assign relay_keep  = rx_keep;
    assign relay_last  = rx_last;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (hdr_xfer) begin
                    state_next = port_match ? PASS : DROP;
                end
            end
            PASS, DROP: begin
                if (last_xfer) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: source/hdr_responder.sv
`timescale 1ns/1ps

module hdr_responder (
    input  logic                    clk,
    input  logic                    rst,

    // Load request from the filter with the received header
    input  logic                    hdr_load,
    output logic                    hdr_busy,
    input  udp_loop_pkg::ip_addr_t  rx_src_ip,
    input  udp_loop_pkg::udp_port_t rx_src_port,
    input  udp_loop_pkg::udp_port_t rx_dst_port,
    input  udp_loop_pkg::udp_len_t  rx_length,

    // Configured values
    input  udp_loop_pkg::ip_addr_t  local_ip,
    input  udp_loop_pkg::ttl_t      ttl,

    // Response header
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_loop_pkg::ip_addr_t  tx_src_ip,
    output udp_loop_pkg::ip_addr_t  tx_dst_ip,
    output udp_loop_pkg::udp_port_t tx_src_port,
    output udp_loop_pkg::udp_port_t tx_dst_port,
    output udp_loop_pkg::udp_len_t  tx_length,
    output udp_loop_pkg::ttl_t      tx_ttl
);

    // Header is held until the sink takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    // Reply goes back to the sender, ports swapped
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            tx_src_ip   <= local_ip;
            tx_dst_ip   <= rx_src_ip;
            tx_src_port <= rx_dst_port;
            tx_dst_port <= rx_src_port;
            tx_length   <= rx_length;
            tx_ttl      <= ttl;
        end
    end

    // Filter waits on this before taking the next header
    assign hdr_busy = tx_hdr_valid;

endmodule

// File: source/payload_relay.sv
`timescale 1ns/1ps

module payload_relay (
    input  logic                clk,
    input  logic                rst,

    // Beats from the filter
    input  logic                relay_valid,
    output logic                relay_ready,
    input  udp_loop_pkg::data_t relay_data,
    input  udp_loop_pkg::keep_t relay_keep,
    input  logic                relay_last,

    // Looped payload
    output logic                tx_valid,
    input  logic                tx_ready,
    output udp_loop_pkg::data_t tx_data,
    output udp_loop_pkg::keep_t tx_keep,
    output logic                tx_last,

    output udp_loop_pkg::led_t  led
);

    logic beat_xfer;
    logic frame_start;

    // Register can take a beat when empty or when its beat leaves now
    assign relay_ready = !tx_valid || tx_ready;
    assign beat_xfer   = relay_valid && relay_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else if (beat_xfer) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_xfer) begin
            tx_data <= relay_data;
            tx_keep <= relay_keep;
            tx_last <= relay_last;
        end
    end

    // Next beat after a last beat opens a new frame
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_start <= 1'b1;
        end else if (beat_xfer) begin
            frame_start <= relay_last;
        end
    end

    // First payload byte of each returned frame on the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
        end else if (beat_xfer && frame_start) begin
            led <= relay_data[7:0];
        end
    end

endmodule

// File: source/udp_loop_top.sv
`timescale 1ns/1ps

module udp_loop_top #(
    parameter udp_loop_pkg::ttl_t RESET_TTL = udp_loop_pkg::DEFAULT_TTL
) (
    input  logic                    clk,
    input  logic                    rst,

    // Received UDP header
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    input  udp_loop_pkg::ip_addr_t  rx_src_ip,
    input  udp_loop_pkg::ip_addr_t  rx_dst_ip,
    input  udp_loop_pkg::udp_port_t rx_src_port,
    input  udp_loop_pkg::udp_port_t rx_dst_port,
    input  udp_loop_pkg::udp_len_t  rx_length,

    // Received payload
    input  logic                    rx_valid,
    output logic                    rx_ready,
    input  udp_loop_pkg::data_t     rx_data,
    input  udp_loop_pkg::keep_t     rx_keep,
    input  logic                    rx_last,

    // Configuration
    input  logic                    cfg_we,
    input  udp_loop_pkg::cfg_addr_e cfg_addr,
    input  udp_loop_pkg::cfg_data_t cfg_wdata,

    // Response header
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_loop_pkg::ip_addr_t  tx_src_ip,
    output udp_loop_pkg::ip_addr_t  tx_dst_ip,
    output udp_loop_pkg::udp_port_t tx_src_port,
    output udp_loop_pkg::udp_port_t tx_dst_port,
    output udp_loop_pkg::udp_len_t  tx_length,
    output udp_loop_pkg::ttl_t      tx_ttl,

    // Looped payload
    output logic                    tx_valid,
    input  logic                    tx_ready,
    output udp_loop_pkg::data_t     tx_data,
    output udp_loop_pkg::keep_t     tx_keep,
    output logic                    tx_last,

    output udp_loop_pkg::led_t      led
);

    import udp_loop_pkg::*;

    ip_addr_t  local_ip;
    udp_port_t listen_port;
    ttl_t      ttl;

    logic      hdr_load;
    logic      hdr_busy;

    logic      relay_valid;
    logic      relay_ready;
    data_t     relay_data;
    keep_t     relay_keep;
    logic      relay_last;

    loop_config #(
        .RESET_TTL(RESET_TTL)
    ) i_loop_config (
        .clk(clk),
        .rst(rst),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .local_ip(local_ip),
        .listen_port(listen_port),
        .ttl(ttl)
    );

    port_filter i_port_filter (
        .clk(clk),
        .rst(rst),
        .listen_port(listen_port),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_dst_port(rx_dst_port),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .rx_data(rx_data),
        .rx_keep(rx_keep),
        .rx_last(rx_last),
        .hdr_load(hdr_load),
        .hdr_busy(hdr_busy),
        .relay_valid(relay_valid),
        .relay_ready(relay_ready),
        .relay_data(relay_data),
        .relay_keep(relay_keep),
        .relay_last(relay_last)
    );

    hdr_responder i_hdr_responder (
        .clk(clk),
        .rst(rst),
        .hdr_load(hdr_load),
        .hdr_busy(hdr_busy),
        .rx_src_ip(rx_src_ip),
        .rx_src_port(rx_src_port),
        .rx_dst_port(rx_dst_port),
        .rx_length(rx_length),
        .local_ip(local_ip),
        .ttl(ttl),
        .tx_hdr_valid(tx_hdr_valid),
        .tx_hdr_ready(tx_hdr_ready),
        .tx_src_ip(tx_src_ip),
        .tx_dst_ip(tx_dst_ip),
        .tx_src_port(tx_src_port),
        .tx_dst_port(tx_dst_port),
        .tx_length(tx_length),
        .tx_ttl(tx_ttl)
    );

    payload_relay i_payload_relay (
        .clk(clk),
        .rst(rst),
        .relay_valid(relay_valid),
        .relay_ready(relay_ready),
        .relay_data(relay_data),
        .relay_keep(relay_keep),
        .relay_last(relay_last),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .tx_data(tx_data),
        .tx_keep(tx_keep),
        .tx_last(tx_last),
        .led(led)
    );

endmodule

// File: sim/udp_loop_tb.sv
`timescale 1ns/1ps

module udp_loop_tb;

    import udp_loop_pkg::*;

    localparam int   CLK_PERIOD      = 100;
    localparam int   NUM_FRAMES      = 200;
    localparam int   MAX_BEATS       = 8;
    localparam int   CYCLES_PER_BEAT = 20;
    localparam int   TIMEOUT_NS      = NUM_FRAMES * MAX_BEATS * CYCLES_PER_BEAT * CLK_PERIOD;
    localparam ttl_t TB_RESET_TTL    = 8'd77;

    logic      clk;
    logic      rst;
    logic      rx_hdr_valid;
    logic      rx_hdr_ready;
    ip_addr_t  rx_src_ip;
    ip_addr_t  rx_dst_ip;
    udp_port_t rx_src_port;
    udp_port_t rx_dst_port;
    udp_len_t  rx_length;
    logic      rx_valid;
    logic      rx_ready;
    data_t     rx_data;
    keep_t     rx_keep;
    logic      rx_last;
    logic      cfg_we;
    cfg_addr_e cfg_addr;
    cfg_data_t cfg_wdata;
    logic      tx_hdr_valid;
    logic      tx_hdr_ready;
    ip_addr_t  tx_src_ip;
    ip_addr_t  tx_dst_ip;
    udp_port_t tx_src_port;
    udp_port_t tx_dst_port;
    udp_len_t  tx_length;
    ttl_t      tx_ttl;
    logic      tx_valid;
    logic      tx_ready;
    data_t     tx_data;
    keep_t     tx_keep;
    logic      tx_last;
    led_t      led;

    // Reference model, reset values 192.168.1.128 and port 1234
    logic [31:0]  model_local_ip    = 32'hC0A8_0180;
    logic [15:0]  model_listen_port = 16'd1234;
    logic [7:0]   model_ttl         = TB_RESET_TTL;
    logic [7:0]   led_model         = 8'h00;
    logic         frame_match       = 1'b0;
    logic         first_beat        = 1'b0;
    logic         hdr_rise_due      = 1'b0;
    logic         hdr_valid_prev    = 1'b0;
    // {src_ip, dst_ip, src_port, dst_port, length, ttl}
    logic [119:0] exp_hdr_q[$];
    // {data, keep, last}
    logic [72:0]  exp_beat_q[$];

    udp_loop_top #(
        .RESET_TTL(TB_RESET_TTL)
    ) i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    task automatic write_config();
        int sel;
        sel       = int'($urandom % 3);
        cfg_wdata = $urandom;
        case (sel)
            0:       cfg_addr = CFG_LOCAL_IP;
            1:       cfg_addr = CFG_LISTEN_PORT;
            default: cfg_addr = CFG_TTL;
        endcase
        cfg_we = 1'b1;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic send_frame();
        int   beats;
        int   b;
        logic accepted;
        beats = 1 + int'($urandom % MAX_BEATS);
        repeat ($urandom % 3) @(negedge clk);
        rx_hdr_valid = 1'b1;
        rx_src_ip    = $urandom;
        rx_dst_ip    = $urandom;
        rx_src_port  = 16'($urandom);
        // About half the frames go to the listen port
        rx_dst_port  = ($urandom % 2 == 0) ? model_listen_port : 16'($urandom);
        rx_length    = 16'(8 + 8 * beats);
        accepted = 1'b0;
        while (!accepted) begin
            #1;
            accepted = rx_hdr_ready;
            @(negedge clk);
        end
        // Scramble the header so a late capture shows up
        rx_hdr_valid = 1'b0;
        rx_src_ip    = $urandom;
        rx_src_port  = 16'($urandom);
        rx_dst_port  = 16'($urandom);
        rx_length    = 16'($urandom);
        for (b = 0; b < beats; b++) begin
            if ($urandom % 4 == 0) begin
                rx_valid = 1'b0;
                @(negedge clk);
            end
            rx_valid = 1'b1;
            rx_data  = {$urandom, $urandom};
            rx_last  = (b == beats - 1);
            rx_keep  = rx_last ? (8'hFF >> ($urandom % 8)) : 8'hFF;
            accepted = 1'b0;
            while (!accepted) begin
                #1;
                accepted = rx_ready;
                @(negedge clk);
            end
        end
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    // Random back-pressure on both output handshakes
    always @(negedge clk) begin
        tx_ready     = ($urandom % 4) != 0;
        tx_hdr_ready = ($urandom % 3) != 0;
    end

    // Sampled mid-cycle, each transfer belongs to the coming rising edge
    always @(negedge clk) begin : monitor
        logic [119:0] hdr;
        logic [72:0]  beat;
        #10;
        if (!rst) begin
            check_value("led", 64'(led), 64'(led_model));
            check_value("tx_hdr_valid rise", 64'(tx_hdr_valid && !hdr_valid_prev),
                        64'(hdr_rise_due));
            hdr_valid_prev = tx_hdr_valid;
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    fail_run("A response header was sent with no matching frame pending");
                end else begin
                    hdr = exp_hdr_q.pop_front();
                    check_value("tx_src_ip", 64'(tx_src_ip), 64'(hdr[119:88]));
                    check_value("tx_dst_ip", 64'(tx_dst_ip), 64'(hdr[87:56]));
                    check_value("tx_src_port", 64'(tx_src_port), 64'(hdr[55:40]));
                    check_value("tx_dst_port", 64'(tx_dst_port), 64'(hdr[39:24]));
                    check_value("tx_length", 64'(tx_length), 64'(hdr[23:8]));
                    check_value("tx_ttl", 64'(tx_ttl), 64'(hdr[7:0]));
                end
            end
            if (tx_valid && tx_ready) begin
                if (exp_beat_q.size() == 0) begin
                    fail_run("A payload beat was sent with no matching beat pending");
                end else begin
                    beat = exp_beat_q.pop_front();
                    check_value("tx_data", tx_data, beat[72:9]);
                    check_value("tx_keep", 64'(tx_keep), 64'(beat[8:1]));
                    check_value("tx_last", 64'(tx_last), 64'(beat[0]));
                end
            end
            hdr_rise_due = 1'b0;
            if (rx_hdr_valid && rx_hdr_ready) begin
                frame_match = (rx_dst_port == model_listen_port);
                first_beat  = 1'b1;
                if (frame_match) begin
                    exp_hdr_q.push_back({model_local_ip, rx_src_ip, rx_dst_port,
                                         rx_src_port, rx_length, model_ttl});
                    hdr_rise_due = 1'b1;
                end
            end
            if (rx_valid && rx_ready) begin
                if (frame_match) begin
                    exp_beat_q.push_back({rx_data, rx_keep, rx_last});
                    if (first_beat) begin
                        led_model = rx_data[7:0];
                    end
                end
                first_beat = 1'b0;
            end
            // Config writes only affect later headers
            if (cfg_we) begin
                case (cfg_addr)
                    CFG_LOCAL_IP:    model_local_ip    = cfg_wdata;
                    CFG_LISTEN_PORT: model_listen_port = cfg_wdata[15:0];
                    CFG_TTL:         model_ttl         = cfg_wdata[7:0];
                    default: begin
                    end
                endcase
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        fail_run("Timeout: the DUT stopped making progress and the run did not finish");
    end

    initial begin : stimulus
        int f;
        clk          = 1'b0;
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_src_ip    = '0;
        rx_dst_ip    = '0;
        rx_src_port  = '0;
        rx_dst_port  = '0;
        rx_length    = '0;
        rx_valid     = 1'b0;
        rx_data      = '0;
        rx_keep      = '0;
        rx_last      = 1'b0;
        cfg_we       = 1'b0;
        cfg_addr     = CFG_LOCAL_IP;
        cfg_wdata    = '0;
        tx_ready     = 1'b0;
        tx_hdr_ready = 1'b0;
        void'($urandom(32'h935));
        repeat (2) @(negedge clk);
        rst = 1'b0;
        #1;
        check_value("tx_hdr_valid", 64'(tx_hdr_valid), 64'd0);
        check_value("tx_valid", 64'(tx_valid), 64'd0);
        check_value("rx_hdr_ready", 64'(rx_hdr_ready), 64'd1);
        check_value("rx_ready", 64'(rx_ready), 64'd0);
        check_value("led", 64'(led), 64'd0);
        @(negedge clk);
        for (f = 0; f < NUM_FRAMES; f++) begin
            if ($urandom % 6 == 0) begin
                write_config();
            end
            send_frame();
        end
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(negedge clk);
        end
        // Any late extra header or beat is caught by the monitor here
        repeat (20) @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: udp_loop.f
source/udp_loop_pkg.sv
source/loop_config.sv
source/port_filter.sv
source/hdr_responder.sv
source/payload_relay.sv
source/udp_loop_top.sv
sim/udp_loop_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module udp_loop_tb -f udp_loop.f -o udp_loop_sim
./obj_dir/udp_loop_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
